// File: hdl/alu_pkg.sv
package alu_pkg;

    typedef logic [31:0] word_t;    // operand / result word
    typedef logic [7:0]  aluop_t;   // alu opcode
    typedef logic [3:0]  count_t;   // queue / fifo occupancy
    typedef logic [2:0]  wb_adr_t;  // wishbone word address

    // alu opcodes, 0 is left unused
    localparam aluop_t ALU_ADDW      = 8'h01;
    localparam aluop_t ALU_SUBW      = 8'h02;
    localparam aluop_t ALU_ADDIW     = 8'h03;
    localparam aluop_t ALU_PCADDU12I = 8'h04;
    localparam aluop_t ALU_CACOP     = 8'h05;
    localparam aluop_t ALU_AND       = 8'h06;
    localparam aluop_t ALU_ANDI      = 8'h07;
    localparam aluop_t ALU_OR        = 8'h08;
    localparam aluop_t ALU_ORI       = 8'h09;
    localparam aluop_t ALU_LU12I     = 8'h0a;
    localparam aluop_t ALU_XOR       = 8'h0b;
    localparam aluop_t ALU_XORI      = 8'h0c;
    localparam aluop_t ALU_NOR       = 8'h0d;
    localparam aluop_t ALU_SLLW      = 8'h0e;
    localparam aluop_t ALU_SLLIW     = 8'h0f;
    localparam aluop_t ALU_SRLW      = 8'h10;
    localparam aluop_t ALU_SRLIW     = 8'h11;
    localparam aluop_t ALU_SRAW      = 8'h12;
    localparam aluop_t ALU_SRAIW     = 8'h13;
    localparam aluop_t ALU_SLT       = 8'h14;
    localparam aluop_t ALU_SLTU      = 8'h15;
    localparam aluop_t ALU_SLTI      = 8'h16;
    localparam aluop_t ALU_SLTUI     = 8'h17;

    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = 2;   // log2 of NUM_LANES
    localparam int CMD_DEPTH  = 4;   // request queue entries
    localparam int CMD_PTR_W  = 2;
    localparam int RES_DEPTH  = 8;   // result fifo entries
    localparam int RES_PTR_W  = 3;

    // register map
    localparam wb_adr_t ADR_REG1   = 3'd0;
    localparam wb_adr_t ADR_REG2   = 3'd1;
    localparam wb_adr_t ADR_OP     = 3'd2;
    localparam wb_adr_t ADR_RESULT = 3'd3;
    localparam wb_adr_t ADR_STATUS = 3'd4;

    typedef struct packed {
        aluop_t opcode;
        word_t  reg1;
        word_t  reg2;
    } alu_req_t;    // 72 bits

    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_t;

endpackage

// File: hdl/regular_alu.sv
module regular_alu (
    input  alu_pkg::aluop_t aluop,
    input  alu_pkg::word_t  reg1,
    input  alu_pkg::word_t  reg2,
    output alu_pkg::word_t  result
);

    import alu_pkg::*;

    logic   do_sub;        // adder runs as subtractor
    logic   signed_cmp;
    logic   reg1_lt_reg2;
    word_t  reg2_mux;
    word_t  sum_result;
    word_t  sra_fill;      // sign bits shifted in by sraw
    logic [4:0] shamt;

    assign do_sub     = (aluop == ALU_SUBW) || (aluop == ALU_SLT) || (aluop == ALU_SLTI);
    assign signed_cmp = (aluop == ALU_SLT) || (aluop == ALU_SLTI);

    assign reg2_mux   = do_sub ? (~reg2 + 32'd1) : reg2;
    assign sum_result = reg1 + reg2_mux;   // single shared adder

    // signed: negative vs positive, or same sign and negative difference
    always_comb begin
        if (signed_cmp) begin
            reg1_lt_reg2 = (reg1[31] && !reg2[31]) ||
                           ((reg1[31] == reg2[31]) && sum_result[31]);
        end else begin
            reg1_lt_reg2 = (reg1 < reg2);   // sltu / sltui
        end
    end

    assign shamt    = reg2[4:0];
    assign sra_fill = {32{reg1[31]}} & ~(32'hffff_ffff >> shamt);

    always_comb begin
        case (aluop)
            ALU_ADDW, ALU_SUBW, ALU_ADDIW, ALU_PCADDU12I, ALU_CACOP: begin
                result = sum_result;
            end
            ALU_AND, ALU_ANDI: begin
                result = reg1 & reg2;
            end
            ALU_OR, ALU_ORI, ALU_LU12I: begin
                result = reg1 | reg2;   // lu12i arrives with reg1 = 0
            end
            ALU_XOR, ALU_XORI: begin
                result = reg1 ^ reg2;
            end
            ALU_NOR: begin
                result = ~(reg1 | reg2);
            end
            ALU_SLLW, ALU_SLLIW: begin
                result = reg1 << shamt;
            end
            ALU_SRLW, ALU_SRLIW: begin
                result = reg1 >> shamt;
            end
            ALU_SRAW, ALU_SRAIW: begin
                result = (reg1 >> shamt) | sra_fill;
            end
            ALU_SLT, ALU_SLTU, ALU_SLTI, ALU_SLTUI: begin
                result = {31'b0, reg1_lt_reg2};
            end
            default: begin
                result = 32'b0;
            end
        endcase
    end

endmodule

// File: hdl/alu_lane.sv
module alu_lane #(
    parameter int LANE_ID = 0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_valid,
    input  alu_pkg::alu_req_t issue_req,
    output logic             lane_valid,
    output alu_pkg::word_t   lane_result
);

    import alu_pkg::*;

    word_t alu_result;

    regular_alu u_alu (
        .aluop  (issue_req.opcode),
        .reg1   (issue_req.reg1),
        .reg2   (issue_req.reg2),
        .result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= issue_valid;   // one cycle latency
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            lane_result <= alu_result;
        end
    end

endmodule

// File: hdl/issue_dispatcher.sv
module issue_dispatcher (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push,
    input  alu_pkg::alu_req_t             push_req,
    output logic                          full,
    input  logic                          room,
    output logic [alu_pkg::NUM_LANES-1:0] issue_valid,
    output alu_pkg::alu_req_t             issue_req
);

    import alu_pkg::*;

    alu_req_t              queue [CMD_DEPTH];
    logic [CMD_PTR_W-1:0]  wr_ptr;
    logic [CMD_PTR_W-1:0]  rd_ptr;
    count_t                count;
    logic [LANE_IDX_W-1:0] rr_ptr;    // next lane to receive work
    logic                  push_ok;
    logic                  issue;

    assign full      = (count == count_t'(CMD_DEPTH));
    assign push_ok   = push && !full;
    assign issue     = room && (count != '0);
    assign issue_req = queue[rd_ptr];

    // one-hot issue to the round-robin lane
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            issue_valid[i] = issue && (rr_ptr == LANE_IDX_W'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            queue[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rr_ptr <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at CMD_DEPTH
            end
            if (issue) begin
                rd_ptr <= rd_ptr + 1'b1;
                rr_ptr <= rr_ptr + 1'b1;
            end
            case ({push_ok, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/result_collector.sv
module result_collector (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [alu_pkg::NUM_LANES-1:0] lane_valid,
    input  alu_pkg::word_t                lane_result [alu_pkg::NUM_LANES],
    output logic                          room,
    input  logic                          pop,
    output alu_pkg::word_t                res_data,
    output alu_pkg::count_t               res_count
);

    import alu_pkg::*;

    word_t                fifo [RES_DEPTH];
    logic [RES_PTR_W-1:0] wr_ptr;
    logic [RES_PTR_W-1:0] rd_ptr;
    count_t               count;
    count_t               n_valid;   // lane outputs landing this edge
    count_t               free;
    word_t                sel_result;
    logic                 push;
    logic                 pop_ok;

    // lanes retire in issue order, so at most one is valid per cycle
    always_comb begin
        sel_result = '0;
        n_valid    = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_valid[i]) begin
                sel_result = lane_result[i];
                n_valid    = n_valid + 1'b1;
            end
        end
    end

    assign push      = |lane_valid;
    assign pop_ok    = pop && (count != '0);
    assign free      = count_t'(RES_DEPTH) - count;
    assign room      = (free > n_valid);   // keep a slot for work now in flight
    assign res_data  = fifo[rd_ptr];
    assign res_count = count;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= sel_result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push and pop together
            endcase
        end
    end

endmodule

// File: hdl/wb_alu_regs.sv
module wb_alu_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  alu_pkg::wb_adr_t  adr,
    input  alu_pkg::word_t    dat_w,
    output alu_pkg::word_t    dat_r,
    output logic              ack,
    output logic              push,
    output alu_pkg::alu_req_t push_req,
    input  logic              full,
    output logic              pop,
    input  alu_pkg::word_t    res_data,
    input  alu_pkg::count_t   res_count
);

    import alu_pkg::*;

    wb_state_t state;
    word_t     reg1_q;
    word_t     reg2_q;
    word_t     rd_data;
    logic      access;
    logic      op_write;
    logic      accept;    // access taken this cycle, ack follows

    assign access   = (state == WB_IDLE) && cyc && stb;
    assign op_write = we && (adr == ADR_OP);
    assign accept   = access && !(op_write && full);   // hold off while queue full
    assign ack      = (state == WB_ACK);

    assign push = accept && op_write;
    assign pop  = accept && !we && (adr == ADR_RESULT) && (res_count != '0);

    always_comb begin
        push_req.opcode = dat_w[7:0];
        push_req.reg1   = reg1_q;
        push_req.reg2   = reg2_q;
    end

    always_comb begin
        case (adr)
            ADR_REG1: begin
                rd_data = reg1_q;
            end
            ADR_REG2: begin
                rd_data = reg2_q;
            end
            ADR_RESULT: begin
                rd_data = (res_count != '0) ? res_data : '0;   // empty reads 0
            end
            ADR_STATUS: begin
                rd_data = {23'b0, full, 4'b0, res_count};
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WB_IDLE;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (accept) begin
                        state <= WB_ACK;
                    end
                end
                WB_ACK: begin
                    state <= WB_IDLE;   // single-cycle ack
                end
                default: begin
                    state <= WB_IDLE;
                end
            endcase
        end
    end

    // host-visible operands
    always_ff @(posedge clk) begin
        if (rst) begin
            reg1_q <= '0;
            reg2_q <= '0;
        end else if (accept && we) begin
            if (adr == ADR_REG1) begin
                reg1_q <= dat_w;
            end
            if (adr == ADR_REG2) begin
                reg2_q <= dat_w;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !we) begin
            dat_r <= rd_data;   // valid with ack
        end
    end

endmodule

// File: hdl/alu_cluster_top.sv
module alu_cluster_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  alu_pkg::wb_adr_t adr,
    input  alu_pkg::word_t   dat_w,
    output alu_pkg::word_t   dat_r,
    output logic             ack
);

    import alu_pkg::*;

    logic                 push;
    alu_req_t             push_req;
    logic                 full;
    logic                 room;
    logic [NUM_LANES-1:0] issue_valid;
    alu_req_t             issue_req;
    logic [NUM_LANES-1:0] lane_valid;
    word_t                lane_result [NUM_LANES];
    logic                 pop;
    word_t                res_data;
    count_t               res_count;

    wb_alu_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .dat_r     (dat_r),
        .ack       (ack),
        .push      (push),
        .push_req  (push_req),
        .full      (full),
        .pop       (pop),
        .res_data  (res_data),
        .res_count (res_count)
    );

    issue_dispatcher u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .push        (push),
        .push_req    (push_req),
        .full        (full),
        .room        (room),
        .issue_valid (issue_valid),
        .issue_req   (issue_req)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        alu_lane #(
            .LANE_ID (i)
        ) u_lane (
            .clk         (clk),
            .rst         (rst),
            .issue_valid (issue_valid[i]),
            .issue_req   (issue_req),     // shared, qualified per lane
            .lane_valid  (lane_valid[i]),
            .lane_result (lane_result[i])
        );
    end

    result_collector u_collect (
        .clk         (clk),
        .rst         (rst),
        .lane_valid  (lane_valid),
        .lane_result (lane_result),
        .room        (room),
        .pop         (pop),
        .res_data    (res_data),
        .res_count   (res_count)
    );

endmodule

// File: verification/alu_cluster_properties.sv
module alu_cluster_properties (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic push,
    input logic full
);
    timeunit 1ns;
    timeprecision 1ps;

    // slave answers only inside an active bus cycle
    ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb))
        else $error("ack raised without cyc and stb");

    single_ack: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack held high for two cycles");

    // back-pressure must hold the opcode write off
    no_push_when_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("request pushed into a full queue");

endmodule

bind alu_cluster_top alu_cluster_properties u_props (
    .clk  (clk),
    .rst  (rst),
    .cyc  (cyc),
    .stb  (stb),
    .ack  (ack),
    .push (push),
    .full (full)
);

// File: verification/alu_cluster_tb.sv
module alu_cluster_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;

    logic    clk;
    logic    rst;
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    word_t   dat_w;
    word_t   dat_r;
    logic    ack;

    int      checks;
    int      errors;
    int      timeouts;
    word_t   expected [$];   // results still owed, oldest first
    word_t   edges [6] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'd1, 32'd31};
    aluop_t  ops [26] = '{ALU_ADDW, ALU_SUBW, ALU_ADDIW, ALU_PCADDU12I, ALU_CACOP, ALU_AND,
                          ALU_ANDI, ALU_OR, ALU_ORI, ALU_LU12I, ALU_XOR, ALU_XORI, ALU_NOR,
                          ALU_SLLW, ALU_SLLIW, ALU_SRLW, ALU_SRLIW, ALU_SRAW, ALU_SRAIW,
                          ALU_SLT, ALU_SLTU, ALU_SLTI, ALU_SLTUI, 8'h00, 8'h18, 8'hff};

    alu_cluster_top dut (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t expected_result(input aluop_t op, input word_t a, input word_t b);
        case (op)
            ALU_ADDW, ALU_ADDIW, ALU_PCADDU12I, ALU_CACOP: return a + b;
            ALU_SUBW: return a - b;
            ALU_AND, ALU_ANDI: return a & b;
            ALU_OR, ALU_ORI, ALU_LU12I: return a | b;
            ALU_XOR, ALU_XORI: return a ^ b;
            ALU_NOR: return ~(a | b);
            ALU_SLLW, ALU_SLLIW: return a << b[4:0];
            ALU_SRLW, ALU_SRLIW: return a >> b[4:0];
            ALU_SRAW, ALU_SRAIW: return word_t'($signed(a) >>> b[4:0]);
            ALU_SLT, ALU_SLTI: return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU, ALU_SLTUI: return {31'b0, a < b};
            default: return '0;   // unknown opcode
        endcase
    endfunction

    task automatic check_value(input word_t got, input word_t exp, input string what);
        checks++;
        assert (got == exp) else begin
            $display("FAIL %0t ns: %s got %08h expected %08h", $time, what, got, exp);
            errors++;
        end
    endtask

    // one classic cycle, stb held through the edge that samples ack
    task automatic bus_access(input logic write, input wb_adr_t addr, input word_t wdata,
                              output word_t rdata);
        int n;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        n     = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (!ack && n < 50);
        if (!ack) begin
            $display("ERROR: no ack within 50 cycles for access to address %0d", addr);
            timeouts++;
        end else begin
            @(posedge clk);
            #2;
        end
        rdata = dat_r;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
    endtask

    task automatic wait_results(input int need);
        word_t st;
        int    n;
        n = 0;
        do begin
            bus_access(1'b0, ADR_STATUS, '0, st);
            n++;
        end while (int'(st[3:0]) < need && n < 50);
        if (int'(st[3:0]) < need) begin
            $display("ERROR: result count stuck at %0d while waiting for %0d", st[3:0], need);
            timeouts++;
        end
    endtask

    task automatic issue_op(input aluop_t op, input word_t a, input word_t b);
        word_t unused;
        bus_access(1'b1, ADR_REG1, a, unused);
        bus_access(1'b1, ADR_REG2, b, unused);
        bus_access(1'b1, ADR_OP, word_t'(op), unused);
        expected.push_back(expected_result(op, a, b));
    endtask

    task automatic read_result(input string what);
        word_t got;
        wait_results(1);
        bus_access(1'b0, ADR_RESULT, '0, got);
        check_value(got, expected.pop_front(), what);
    endtask

    initial begin
        word_t st;
        word_t a;
        word_t b;
        void'($urandom(58));
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        dat_w    = '0;
        rst      = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        bus_access(1'b0, ADR_STATUS, '0, st);
        check_value(st, '0, "status after reset");
        bus_access(1'b0, ADR_RESULT, '0, st);
        check_value(st, '0, "result read while empty");
        bus_access(1'b0, ADR_STATUS, '0, st);
        check_value(st, '0, "count after empty read");
        bus_access(1'b1, ADR_REG1, 32'hdead_beef, st);
        bus_access(1'b1, ADR_REG2, 32'h1234_5678, st);
        bus_access(1'b0, ADR_REG1, '0, st);
        check_value(st, 32'hdead_beef, "reg1 readback");
        bus_access(1'b0, ADR_REG2, '0, st);
        check_value(st, 32'h1234_5678, "reg2 readback");
        bus_access(1'b0, 3'd6, '0, st);
        check_value(st, '0, "unmapped address");

        // edge pairs first, then random operands
        foreach (ops[i]) begin
            for (int j = 0; j < 8; j++) begin
                a = (j < 6) ? edges[j] : $urandom();
                b = (j < 6) ? edges[5 - j] : $urandom();
                issue_op(ops[i], a, b);
                read_result($sformatf("opcode %02h", ops[i]));
            end
        end

        issue_op(ALU_SLT, 32'h8000_0000, 32'd1);
        issue_op(ALU_SLTU, 32'h8000_0000, 32'd1);
        wait_results(2);
        bus_access(1'b0, ADR_RESULT, '0, st);
        check_value(st, 32'd1, "signed 80000000 < 1");
        bus_access(1'b0, ADR_RESULT, '0, st);
        check_value(st, 32'd0, "unsigned 80000000 < 1");
        expected.delete();

        // 8 land in the fifo, 4 wait in the queue
        for (int k = 0; k < 12; k++) begin
            issue_op(ops[k % 23], $urandom(), $urandom());
        end
        wait_results(8);
        bus_access(1'b0, ADR_STATUS, '0, st);
        check_value(st, 32'h108, "status with fifo and queue full");
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = ADR_OP;
        dat_w = word_t'(ALU_ADDW);
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            #2;
            check_value({31'b0, ack}, '0, "ack on opcode write to full queue");
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        for (int k = 0; k < 12; k++) begin
            read_result($sformatf("burst result %0d", k));
        end
        bus_access(1'b0, ADR_STATUS, '0, st);
        check_value(st, '0, "status after draining burst");

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: alu_cluster.f
hdl/alu_pkg.sv
hdl/regular_alu.sv
hdl/alu_lane.sv
hdl/issue_dispatcher.sv
hdl/result_collector.sv
hdl/wb_alu_regs.sv
hdl/alu_cluster_top.sv
verification/alu_cluster_properties.sv
verification/alu_cluster_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the alu cluster testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module alu_cluster_tb \
    -f alu_cluster.f \
    -o alu_cluster_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/alu_cluster_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
